//--- compile.f
+incdir+rtl
rtl/cr16_isa_pkg.sv
rtl/cr16_bus_pkg.sv
rtl/fetch_unit.sv
rtl/control_and_decoder.sv
rtl/regfile.sv
rtl/alu.sv
rtl/cr16_core.sv
bench/tb_cr16_core.sv

//--- Bender.yml
package:
  name: cr16_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cr16_isa_pkg.sv
      - rtl/cr16_bus_pkg.sv
      - rtl/fetch_unit.sv
      - rtl/control_and_decoder.sv
      - rtl/regfile.sv
      - rtl/alu.sv
      - rtl/cr16_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/tb_cr16_core.sv

//--- bench/tb_cr16_core.sv
// cr16_core testbench with clock, reset, wishbone slave, reference model, assertions and watchdog
`timescale 1ns/1ps
`include "cr16_consts.svh"

module tb_cr16_core;
    import cr16_isa_pkg::*;
    import cr16_bus_pkg::*;

    localparam int MAX_WAIT = 3; // slave wait states 0 .. 3
    localparam int N_TESTS  = 5;

    logic       clk;
    logic       reset;
    wb_req_t    ibus_req;
    wb_rsp_t    ibus_rsp;
    retire_t    retire;
    flags_t     flags;

    cr16_word_t prog [256];        // instruction memory with nop fill past the program
    int         prog_len;
    int         test_end [N_TESTS]; // program index after each test
    string      test_name [N_TESTS];
    int         errors;
    longint     limit_ns;           // watchdog time, zero until the program is built
    logic       bus_live;           // reset seen released at the last rising edge
    logic       busy;               // slave inside a transfer
    int         wait_left;

    cr16_word_t m_regs [16];        // reference register file
    flags_t     m_flags;
    int         n_acks;
    int         phase;              // cycles since the last ack saturating at 3
    logic       exp_wr;
    reg_idx_t   exp_rdest;
    cr16_word_t exp_data;
    pc_t        exp_pc;
    flags_t     exp_flags;          // after the current instruction
    flags_t     prev_flags;         // before it
    pc_t        exp_adr;
    logic       exp_valid_now;
    flags_t     exp_flags_now;

    cr16_core u_dut (
        .clk      (clk),
        .reset    (reset),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .retire   (retire),
        .flags    (flags)
    );

    always #10 clk = ~clk;

    assign exp_adr       = pc_t'(n_acks);                   // one word per instruction
    assign exp_valid_now = exp_wr && (phase == 2);          // execute cycle
    assign exp_flags_now = (phase == 3) ? exp_flags : prev_flags;

    task automatic log_mismatch(input string sig, input logic [15:0] got,
                                input logic [15:0] exp);
        errors++;
        $display("error at %0d ns: %s = %h, expected %h", $time, sig, got, exp);
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("failure at %0d ns: %s", $time, msg);
    endtask

    function automatic cr16_word_t rr_word(input alu_op_t op, input reg_idx_t rd,
                                           input reg_idx_t rs);
        return {4'b0000, rd, 4'(op), rs};
    endfunction

    function automatic cr16_word_t imm_word(input alu_op_t op, input reg_idx_t rd,
                                            input logic [7:0] imm);
        return {4'(op), rd, imm};
    endfunction

    function automatic reg_idx_t rand_reg();
        return reg_idx_t'($urandom);
    endfunction

    task automatic emit_word(input cr16_word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        alu_op_t arith [10] = '{op_add, op_addu, op_addc, op_sub, op_subc,
                                op_and, op_or, op_xor, op_not, op_mov};
        alu_op_t sop;
        for (int i = 0; i < 256; i++) begin
            prog[i] = {4'b0000, 4'(i >> 4), 4'b0000, 4'(i)}; // nop with fields from the address
        end
        prog_len = 0;
        for (int r = 0; r < 16; r++) begin                     // random word into every register
            emit_word(imm_word(op_mov, 4'(r), 8'($urandom)));
            emit_word(imm_word(op_lsh, 4'(r), 8'd8));
            emit_word(imm_word(op_xor, 4'(r), 8'($urandom)));
        end
        test_end[0] = prog_len;
        for (int i = 0; i < 40; i++) begin
            emit_word(rr_word(arith[$urandom % 10], rand_reg(), rand_reg()));
        end
        test_end[1] = prog_len;
        for (int i = 0; i < 40; i++) begin                     // imm8 of either sign
            emit_word(imm_word(arith[$urandom % 10], rand_reg(), 8'($urandom)));
        end
        test_end[2] = prog_len;
        emit_word(imm_word(op_mov, 4'd13, 8'hf9));             // -7 shifts right
        emit_word(imm_word(op_mov, 4'd14, 8'h05));             // shift left by 5
        emit_word(imm_word(op_mov, 4'd12, 8'h80));             // negative value for ashu fill
        for (int i = 0; i < 30; i++) begin
            sop = (i % 2 == 0) ? op_lsh : op_ashu;
            if (i % 3 == 0) begin                              // amount from r13 .. r15
                emit_word(rr_word(sop, 4'($urandom % 13), 4'(13 + $urandom % 3)));
            end else begin
                emit_word(imm_word(sop, 4'($urandom % 13), 8'(int'($urandom % 41) - 20)));
            end
        end
        test_end[3] = prog_len;
        for (int k = 0; k < 10; k++) begin
            emit_word(rr_word(op_add, rand_reg(), rand_reg()));
            emit_word(rr_word(op_addc, rand_reg(), rand_reg())); // carry from the add
            emit_word(rr_word(op_subc, rand_reg(), rand_reg())); // borrow from the addc
            if (k < 3) begin
                emit_word(rr_word(op_cmp, 4'(k), 4'(k)));        // equal operands
            end else begin
                emit_word(k[0] ? imm_word(op_cmp, rand_reg(), 8'($urandom))
                               : rr_word(op_cmp, rand_reg(), rand_reg()));
            end
            emit_word(rr_word(op_nop, rand_reg(), rand_reg())); // flags must survive
        end
        test_end[4] = prog_len;
    endtask

    // model update for one fetched word with expectations visible after the ack edge
    task automatic model_step(input cr16_word_t w, input pc_t at);
        logic       rr;
        logic [3:0] opc;
        cr16_word_t a;
        cr16_word_t b;
        cr16_word_t res;
        flags_t     f;
        int         cin;
        int         wide;
        int         swide;
        int         amt;
        int         n;
        rr    = (w[15:12] == 4'd0);
        opc   = rr ? w[7:4] : w[15:12];
        a     = m_regs[w[11:8]];
        b     = rr ? m_regs[w[3:0]] : {{8{w[7]}}, w[7:0]};
        cin   = int'(m_flags[`CR16_FLAG_C]);
        res   = '0;
        f     = '0;
        amt   = int'($signed(b));
        n     = (amt < 0) ? -amt : amt;
        if (n > 15) n = 15;
        case (opc)
            op_and:  res = a & b;
            op_or:   res = a | b;
            op_xor:  res = a ^ b;
            op_not:  res = ~b;
            op_mov:  res = b;
            op_lsh:  res = (amt < 0) ? a >> n : a << n;
            op_ashu: res = (amt < 0) ? cr16_word_t'($signed(a) >>> n) : a << n;
            op_add, op_addu, op_addc: begin
                if (opc != op_addc) cin = 0;
                wide  = int'(a) + int'(b) + cin;
                swide = int'($signed(a)) + int'($signed(b)) + cin;
                res   = wide[15:0];
                f[`CR16_FLAG_C] = (wide > 65535);
                f[`CR16_FLAG_F] = (swide > 32767) || (swide < -32768);
            end
            op_sub, op_subc, op_cmp: begin
                if (opc != op_subc) cin = 0;            // borrow only on subc
                wide  = int'(a) - int'(b) - cin;
                swide = int'($signed(a)) - int'($signed(b)) - cin;
                res   = wide[15:0];
                f[`CR16_FLAG_C] = (wide < 0);
                f[`CR16_FLAG_F] = (swide > 32767) || (swide < -32768);
            end
            default: ;
        endcase
        if (opc == op_cmp) begin
            f[`CR16_FLAG_Z] = (wide == 0);  // a equals b
            f[`CR16_FLAG_N] = (swide < 0);  // signed a below b
            f[`CR16_FLAG_L] = (wide < 0);   // unsigned a below b
        end else begin
            f[`CR16_FLAG_Z] = (res == '0);
            f[`CR16_FLAG_N] = res[15];
        end
        exp_wr     <= (opc != op_cmp) && (opc != op_nop);
        exp_rdest  <= w[11:8];
        exp_data   <= res;
        exp_pc     <= at;
        prev_flags <= m_flags;
        if (opc != op_nop) m_flags = f;
        exp_flags  <= m_flags;
        if ((opc != op_cmp) && (opc != op_nop)) m_regs[w[11:8]] = res;
    endtask

    // wishbone slave with random wait states and junk dat outside ack
    always @(negedge clk) begin
        ibus_rsp.ack = 1'b0;
        ibus_rsp.dat = cr16_word_t'($urandom);
        if (bus_live && ibus_req.stb) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = int'($urandom % (MAX_WAIT + 1));
            end
            if (wait_left == 0) begin
                ibus_rsp.ack = 1'b1;
                ibus_rsp.dat = prog[ibus_req.adr[7:0]];
                busy         = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge clk) begin
        bus_live <= reset;
        if (reset && ibus_req.stb && ibus_rsp.ack) begin // ir loads on this edge
            model_step(ibus_rsp.dat, ibus_req.adr);
            n_acks <= n_acks + 1;
            phase  <= 1;
        end else if (phase < 3) begin
            phase <= phase + 1;
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        !reset |-> !ibus_req.cyc && !ibus_req.stb && !retire.valid)
        else note_failure("bus or retire active while reset is held");
    a_adr: assert property (@(posedge clk) disable iff (!reset)
        ibus_req.stb |-> ibus_req.adr == exp_adr)
        else log_mismatch("ibus_req.adr", $sampled(ibus_req.adr), $sampled(exp_adr));
    a_hold: assert property (@(posedge clk) disable iff (!reset)
        ($past(ibus_req.stb) && !$past(ibus_rsp.ack))
            |-> ibus_req.stb && (ibus_req.adr == $past(ibus_req.adr)))
        else note_failure("stb dropped or adr moved during a wait state");
    a_read_only: assert property (@(posedge clk) disable iff (!reset)
        (ibus_req.cyc == ibus_req.stb) && !ibus_req.we)
        else note_failure("cyc and stb differ, or we is high on a fetch");
    a_retire_valid: assert property (@(posedge clk) disable iff (!reset)
        retire.valid == exp_valid_now)
        else log_mismatch("retire.valid", 16'($sampled(retire.valid)),
                          16'($sampled(exp_valid_now)));
    a_retire_rdest: assert property (@(posedge clk) disable iff (!reset)
        retire.valid |-> retire.rdest == exp_rdest)
        else log_mismatch("retire.rdest", 16'($sampled(retire.rdest)),
                          16'($sampled(exp_rdest)));
    a_retire_data: assert property (@(posedge clk) disable iff (!reset)
        retire.valid |-> retire.data == exp_data)
        else log_mismatch("retire.data", $sampled(retire.data), $sampled(exp_data));
    a_retire_pc: assert property (@(posedge clk) disable iff (!reset)
        retire.valid |-> retire.pc == exp_pc)
        else log_mismatch("retire.pc", $sampled(retire.pc), $sampled(exp_pc));
    a_flags: assert property (@(posedge clk) disable iff (!reset)
        flags == exp_flags_now)
        else log_mismatch("flags", 16'($sampled(flags)), 16'($sampled(exp_flags_now)));

    // watchdog sized for the worst case per instruction plus reset and drain
    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("watchdog: program did not complete within %0d ns", limit_ns);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int t_errors;
        int err_mark;
        int failed_tests;
        void'($urandom(32'h1890_cc9d));
        clk          = 1'b0;
        reset        = 1'b0;
        ibus_rsp     = '0;
        bus_live     = 1'b0;
        busy         = 1'b0;
        wait_left    = 0;
        errors       = 0;
        err_mark     = 0;
        failed_tests = 0;
        n_acks       = 0;
        phase        = 3;
        m_flags      = '0;
        exp_wr       = 1'b0;
        exp_rdest    = '0;
        exp_data     = '0;
        exp_pc       = '0;
        exp_flags    = '0;
        prev_flags   = '0;
        for (int r = 0; r < 16; r++) m_regs[r] = '0;
        test_name = '{"reset and fetch", "register-register", "immediate",
                      "shifts", "flags and carry"};
        build_program();
        limit_ns = longint'(prog_len * (3 + MAX_WAIT + 2) + 40) * 20;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            while (n_acks < test_end[t]) @(negedge clk);
            repeat (4) @(negedge clk); // last write and its flags
            t_errors = errors - err_mark;
            err_mark = errors;
            if (t_errors != 0) failed_tests++;
            $display("test %0d %s: %s, %0d error(s)", t + 1, test_name[t],
                     (t_errors == 0) ? "ok" : "bad", t_errors);
        end
        $display("tests: %0d, failed tests: %0d, errors: %0d", N_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- rtl/cr16_core.sv
// cr16 core top: fetch unit, control/decoder, register file and alu, plus retire port
`timescale 1ns/1ps

module cr16_core (
    input  logic                  clk,
    input  logic                  reset,
    output cr16_bus_pkg::wb_req_t ibus_req,
    input  cr16_bus_pkg::wb_rsp_t ibus_rsp,
    output cr16_bus_pkg::retire_t retire,
    output cr16_isa_pkg::flags_t  flags
);
    import cr16_isa_pkg::*;

    logic       fetch_req;
    logic       fetch_done;
    logic       pc_en;
    cr16_word_t instr;
    pc_t        pc;
    ctrl_t      ctrl;
    cr16_word_t rdata_a;
    cr16_word_t rdata_b;
    cr16_word_t alu_result;

    fetch_unit u_fetch (
        .clk        (clk),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .pc_en      (pc_en),
        .ibus_rsp   (ibus_rsp),
        .ibus_req   (ibus_req),
        .fetch_done (fetch_done),
        .instr      (instr),
        .pc         (pc)
    );

    control_and_decoder u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .fetch_done (fetch_done),
        .instr      (instr),
        .fetch_req  (fetch_req),
        .pc_en      (pc_en),
        .ctrl       (ctrl)
    );

    regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .wdata   (alu_result), // writeback straight from the alu
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    alu u_alu (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .a        (rdata_a),
        .rsrc_val (rdata_b),
        .result   (alu_result),
        .flags    (flags)
    );

    // retire mirrors the regfile write, pc still points at this instruction
    assign retire.valid = ctrl.reg_we;
    assign retire.rdest = ctrl.rdest;
    assign retire.data  = alu_result;
    assign retire.pc    = pc;

endmodule

//--- rtl/alu.sv
// combinational cr16 alu with b-operand mux, shifter and registered status flags
`timescale 1ns/1ps
`include "cr16_consts.svh"

module alu (
    input  logic                     clk,
    input  logic                     reset,
    input  cr16_isa_pkg::ctrl_t      ctrl,
    input  cr16_isa_pkg::cr16_word_t a,
    input  cr16_isa_pkg::cr16_word_t rsrc_val,
    output cr16_isa_pkg::cr16_word_t result,
    output cr16_isa_pkg::flags_t     flags
);
    import cr16_isa_pkg::*;

    localparam int MSB = `CR16_DATA_W - 1;

    cr16_word_t            b;
    logic                  cin;        // stored carry
    logic                  add_cin;
    logic                  sub_bin;
    logic [`CR16_DATA_W:0] sum;        // carry in top bit
    logic [`CR16_DATA_W:0] diff;       // borrow in top bit
    logic                  add_ovf;
    logic                  sub_ovf;
    logic                  shift_left;
    cr16_word_t            shift_mag;
    logic [3:0]            shamt;
    cr16_word_t            lsh_res;
    cr16_word_t            ashu_res;
    cr16_word_t            res;
    flags_t                flags_d;
    flags_t                flags_q;

    assign b   = ctrl.imm_en ? ctrl.imm : rsrc_val;
    assign cin = flags_q[`CR16_FLAG_C];

    // add and subtract families share one adder each
    assign add_cin = (ctrl.op == op_addc) && cin;
    assign sub_bin = (ctrl.op == op_subc) && cin;
    assign sum     = {1'b0, a} + {1'b0, b} + add_cin;
    assign diff    = {1'b0, a} - {1'b0, b} - sub_bin;
    assign add_ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
    assign sub_ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

    // signed b: positive shifts left, negative shifts right
    assign shift_left = !b[MSB];
    assign shift_mag  = shift_left ? b : -b;
    assign shamt      = (shift_mag > `CR16_SHAMT_MAX) ? 4'(`CR16_SHAMT_MAX) : shift_mag[3:0];
    assign lsh_res    = shift_left ? (a << shamt) : (a >> shamt);
    assign ashu_res   = shift_left ? (a << shamt) : cr16_word_t'($signed(a) >>> shamt);

    always_comb begin
        case (ctrl.op)
            op_and:                    res = a & b;
            op_or:                     res = a | b;
            op_xor:                    res = a ^ b;
            op_not:                    res = ~b;
            op_mov:                    res = b;
            op_lsh:                    res = lsh_res;
            op_ashu:                   res = ashu_res;
            op_add, op_addu, op_addc:  res = sum[MSB:0];
            op_sub, op_subc, op_cmp:   res = diff[MSB:0]; // cmp result discarded
            default:                   res = '0;
        endcase
    end

    always_comb begin
        flags_d = '0; // logic and shift ops clear c and f
        case (ctrl.op)
            op_add, op_addu, op_addc: begin
                flags_d[`CR16_FLAG_C] = sum[`CR16_DATA_W];
                flags_d[`CR16_FLAG_F] = add_ovf;
            end
            op_sub, op_subc, op_cmp: begin
                flags_d[`CR16_FLAG_C] = diff[`CR16_DATA_W];
                flags_d[`CR16_FLAG_F] = sub_ovf;
            end
            default: ;
        endcase
        if (ctrl.op == op_cmp) begin
            flags_d[`CR16_FLAG_Z] = (a == b);
            flags_d[`CR16_FLAG_N] = ($signed(a) < $signed(b));
            flags_d[`CR16_FLAG_L] = (a < b);
        end else begin
            flags_d[`CR16_FLAG_Z] = (res == '0);
            flags_d[`CR16_FLAG_N] = res[MSB];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            flags_q <= '0;
        end else if (ctrl.flags_we) begin // execute edge, never on nop
            flags_q <= flags_d;
        end
    end

    assign result = res;
    assign flags  = flags_q;

endmodule

//--- rtl/regfile.sv
// sixteen-entry register file, two combinational reads and one one-hot write
`timescale 1ns/1ps
`include "cr16_consts.svh"

module regfile (
    input  logic                     clk,
    input  logic                     reset,
    input  cr16_isa_pkg::ctrl_t      ctrl,
    input  cr16_isa_pkg::cr16_word_t wdata,
    output cr16_isa_pkg::cr16_word_t rdata_a,
    output cr16_isa_pkg::cr16_word_t rdata_b
);
    import cr16_isa_pkg::*;

    cr16_word_t regs [`CR16_NUM_REGS];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `CR16_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_we) begin
            for (int i = 0; i < `CR16_NUM_REGS; i++) begin
                if (ctrl.reg_en[i]) begin // one-hot select from decode
                    regs[i] <= wdata;
                end
            end
        end
    end

    // a is the destination register, cr16 two-operand style
    assign rdata_a = regs[ctrl.rdest];
    assign rdata_b = regs[ctrl.rsrc];

endmodule

//--- rtl/control_and_decoder.sv
// control fsm (fetch, decode, execute) and instruction decoder for the cr16 subset
`timescale 1ns/1ps
`include "cr16_consts.svh"

module control_and_decoder (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     fetch_done,
    input  cr16_isa_pkg::cr16_word_t instr,
    output logic                     fetch_req,
    output logic                     pc_en,
    output cr16_isa_pkg::ctrl_t      ctrl
);
    import cr16_isa_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        rr_form;    // top nibble zero
    logic [3:0]  op_raw;
    logic        op_known;
    alu_op_t     op;
    logic        in_exec;
    logic        writes_reg;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= fetch;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            fetch: begin
                if (fetch_done) begin // ack edge loads ir
                    state_next = decode;
                end
            end
            decode:  state_next = execute;
            execute: state_next = fetch;
            default: state_next = fetch;
        endcase
    end

    // opcode field moves with the form
    assign rr_form  = (instr[15:12] == 4'b0000);
    assign op_raw   = rr_form ? instr[7:4] : instr[15:12];
    assign op_known = (op_raw <= 4'b1101);                      // 1110 / 1111 unused
    assign op       = op_known ? alu_op_t'(op_raw) : op_nop;    // unused codes run as nop

    assign in_exec    = (state == execute);
    assign writes_reg = (op != op_cmp) && (op != op_nop);

    assign fetch_req = reset && (state == fetch); // bus cycle through fetch but never in reset
    assign pc_en     = in_exec;                   // pc steps at the execute edge

    always_comb begin
        ctrl          = '0;
        ctrl.op       = op;
        ctrl.rdest    = instr[11:8];
        ctrl.rsrc     = instr[3:0];
        ctrl.imm_en   = !rr_form;
        ctrl.imm      = {{(`CR16_DATA_W-8){instr[7]}}, instr[7:0]}; // sign extend
        ctrl.reg_we   = in_exec && writes_reg;
        ctrl.flags_we = in_exec && (op != op_nop); // cmp writes flags only
        if (in_exec && writes_reg) begin
            ctrl.reg_en = reg_onehot_t'(1) << instr[11:8];
        end
    end

endmodule

//--- rtl/fetch_unit.sv
// program counter, instruction register and wishbone classic read master
`timescale 1ns/1ps

module fetch_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     fetch_req,
    input  logic                     pc_en,
    input  cr16_bus_pkg::wb_rsp_t    ibus_rsp,
    output cr16_bus_pkg::wb_req_t    ibus_req,
    output logic                     fetch_done,
    output cr16_isa_pkg::cr16_word_t instr,
    output cr16_isa_pkg::pc_t        pc
);
    import cr16_isa_pkg::*;

    pc_t        pc_q;
    cr16_word_t ir_q;
    logic       beat; // stb and ack together end the cycle

    assign beat = fetch_req && ibus_rsp.ack;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q <= '0;
        end else if (pc_en) begin
            pc_q <= pc_q + pc_t'(1); // next word
        end
    end

    // instruction register loads on the ack edge
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir_q <= '0;
        end else if (beat) begin
            ir_q <= ibus_rsp.dat;
        end
    end

    // cyc/stb follow the request while pc holds adr until execute
    assign ibus_req.cyc = fetch_req;
    assign ibus_req.stb = fetch_req;
    assign ibus_req.we  = 1'b0;  // reads only
    assign ibus_req.adr = pc_q;

    assign fetch_done = beat;
    assign instr      = ir_q;
    assign pc         = pc_q;

endmodule

//--- rtl/cr16_bus_pkg.sv
// wishbone classic master request, slave response and register-write retire event
package cr16_bus_pkg;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;  // fetch only, stays low
        cr16_isa_pkg::pc_t adr; // word address
    } wb_req_t;

    typedef struct packed {
        logic                     ack;
        cr16_isa_pkg::cr16_word_t dat; // valid with ack
    } wb_rsp_t;

    typedef struct packed {
        logic                     valid; // one cycle per committed write
        cr16_isa_pkg::reg_idx_t   rdest;
        cr16_isa_pkg::cr16_word_t data;
        cr16_isa_pkg::pc_t        pc;    // address of the retiring instruction
    } retire_t;

endpackage

//--- rtl/cr16_isa_pkg.sv
// isa types: word, register index, pc, flags, alu opcode enum, decoded control struct, fsm state
`include "cr16_consts.svh"

package cr16_isa_pkg;

    typedef logic [`CR16_DATA_W-1:0]    cr16_word_t;  // data word
    typedef logic [`CR16_REG_IDX_W-1:0] reg_idx_t;    // register number
    typedef logic [`CR16_ADDR_W-1:0]    pc_t;         // instruction word address
    typedef logic [`CR16_FLAG_W-1:0]    flags_t;      // c l f n z
    typedef logic [`CR16_NUM_REGS-1:0]  reg_onehot_t; // one bit per register

    // opcode field, same code in rr (instr[7:4]) and imm (instr[15:12]) forms
    typedef enum logic [3:0] {
        op_nop  = 4'b0000,
        op_and  = 4'b0001,
        op_or   = 4'b0010,
        op_xor  = 4'b0011,
        op_lsh  = 4'b0100,
        op_add  = 4'b0101,
        op_addu = 4'b0110,
        op_addc = 4'b0111,
        op_not  = 4'b1000,
        op_sub  = 4'b1001,
        op_subc = 4'b1010,
        op_cmp  = 4'b1011,
        op_ashu = 4'b1100,
        op_mov  = 4'b1101
    } alu_op_t;

    typedef struct packed {
        alu_op_t     op;
        reg_idx_t    rdest;    // also operand a
        reg_idx_t    rsrc;
        logic        imm_en;   // b from immediate
        cr16_word_t  imm;      // sign-extended imm8
        logic        reg_we;
        reg_onehot_t reg_en;   // write select
        logic        flags_we;
    } ctrl_t;

    typedef enum logic [1:0] {
        fetch,
        decode,
        execute
    } ctrl_state_t;

endpackage

//--- rtl/cr16_consts.svh
// datapath width, register count, address width, shift cap and status flag bit positions
`ifndef CR16_CONSTS_SVH
`define CR16_CONSTS_SVH

// datapath and register file
`define CR16_DATA_W    16 // one machine word
`define CR16_NUM_REGS  16 // r0 .. r15
`define CR16_REG_IDX_W 4  // bits to index the register file

// instruction memory
`define CR16_ADDR_W    16 // word address, one instruction per word

// shifter
`define CR16_SHAMT_MAX 15 // larger magnitudes saturate here

// processor status flags, packed psr subset
`define CR16_FLAG_W    5
`define CR16_FLAG_C    0  // carry / borrow out
`define CR16_FLAG_L    1  // unsigned less-than on cmp
`define CR16_FLAG_F    2  // signed overflow
`define CR16_FLAG_N    3  // negative, or signed less-than on cmp
`define CR16_FLAG_Z    4  // zero, or equal on cmp

`endif
